// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    opR      = 7'b0110011,
    opImm    = 7'b0010011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opBranch = 7'b1100011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluSlt = 4'd4
  } aluOpE;

  // Operand source in EX
  typedef enum logic [1:0] {
    fwdReg = 2'd0,
    fwdWb  = 2'd1,
    fwdMem = 2'd2
  } fwdSelE;

  typedef struct packed {
    logic  branch;
    logic  memRead;
    logic  memWrite;
    logic  memToReg;
    logic  regWrite;
    logic  aluSrc;
    aluOpE aluOp;
  } ctrlT;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } ifIdT;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] rs1Value;
    logic [31:0] rs2Value;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    ctrlT        ctrl;
  } idExT;

  typedef struct packed {
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [4:0]  rd;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    logic        regWrite;
  } exMemT;

  typedef struct packed {
    logic [31:0] memData;
    logic [31:0] aluResult;
    logic [4:0]  rd;
    logic        memToReg;
    logic        regWrite;
  } memWbT;

  // One entry per register write
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } retireT;

endpackage

`default_nettype wire

// File: hw/Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu import cpuPkg::*; (
  input  aluOpE       op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        zero
);

  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {31'd0, lessThan};
      default: result = '0;
    endcase
  end

  // Used by BEQ
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// File: hw/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] wrData,
  input  logic        wrEn,
  output logic [31:0] rs1Value,
  output logic [31:0] rs2Value
);

  logic [31:0] regs [32];
  logic        writing;

  assign writing = wrEn && (rd != 5'd0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writing) begin
      regs[rd] <= wrData;
    end
  end

  // Write-first bypass so WB and ID can overlap
  assign rs1Value = (writing && rd == rs1) ? wrData : regs[rs1];
  assign rs2Value = (writing && rd == rs2) ? wrData : regs[rs2];

endmodule

`default_nettype wire

// File: hw/DecodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeUnit import cpuPkg::*; (
  input  logic        clk,
  input  logic [31:0] instr,
  output ctrlT        ctrl,
  output logic [31:0] imm
);

  opcodeE     opcode;
  logic [2:0] funct3;
  logic       funct7b5;

  assign opcode   = opcodeE'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  always_comb begin
    ctrl = '0;
    case (opcode)
      opR: begin
        ctrl.regWrite = 1'b1;
        case (funct3)
          3'b111:  ctrl.aluOp = aluAnd;
          3'b110:  ctrl.aluOp = aluOr;
          3'b010:  ctrl.aluOp = aluSlt;
          default: ctrl.aluOp = funct7b5 ? aluSub : aluAdd;
        endcase
      end
      opImm: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opLoad: begin
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opStore: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBranch: begin
        // BEQ compares by subtraction
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      opImm, opLoad: imm = {{20{instr[31]}}, instr[31:20]};
      opStore:       imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      opBranch:      imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      default:       imm = '0;
    endcase
  end

  // A decoded instruction never both reads and writes data memory
  assert property (@(posedge clk) !(ctrl.memRead && ctrl.memWrite))
    else $error("Decode drives memRead and memWrite together");

endmodule

`default_nettype wire

// File: hw/HazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module HazardUnit import cpuPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic [4:0] idRs1,
  input  logic [4:0] idRs2,
  input  logic [4:0] exRs1,
  input  logic [4:0] exRs2,
  input  logic [4:0] exRd,
  input  logic       exMemRead,
  input  logic [4:0] memRd,
  input  logic       memRegWrite,
  input  logic [4:0] wbRd,
  input  logic       wbRegWrite,
  output logic       stall,
  output fwdSelE     fwdA,
  output fwdSelE     fwdB
);

  // Youngest producer wins
  function automatic fwdSelE pickFwd(input logic [4:0] src);
    if (memRegWrite && memRd != 5'd0 && memRd == src) begin
      return fwdMem;
    end else if (wbRegWrite && wbRd != 5'd0 && wbRd == src) begin
      return fwdWb;
    end
    return fwdReg;
  endfunction

  assign fwdA = pickFwd(exRs1);
  assign fwdB = pickFwd(exRs2);

  // Load result not ready until MEM
  assign stall = exMemRead && (exRd != 5'd0) && (exRd == idRs1 || exRd == idRs2);

  // The inserted bubble clears the load from EX, so a stall lasts one cycle
  assert property (@(posedge clk) disable iff (!arstN) stall |=> !stall)
    else $error("Load-use stall held for two cycles");

endmodule

`default_nettype wire

// File: hw/MemoryHandler.sv
`timescale 1ns/1ps
`default_nettype none

module MemoryHandler #(
  parameter int imemWords = 64,
  parameter int dmemWords = 64
) (
  input  logic                         clk,
  input  logic                         loadEn,
  input  logic [$clog2(imemWords)-1:0] loadAddr,
  input  logic [31:0]                  loadData,
  input  logic [31:0]                  pc,
  input  logic [31:0]                  dataAddr,
  input  logic [31:0]                  dataIn,
  input  logic                         dataWrite,
  output logic [31:0]                  instr,
  output logic [31:0]                  dataOut
);

  localparam int imemAw = $clog2(imemWords);
  localparam int dmemAw = $clog2(dmemWords);

  logic [31:0] imem [imemWords];
  logic [31:0] dmem [dmemWords];

  logic [imemAw-1:0] fetchIdx;
  logic [dmemAw-1:0] dataIdx;

  // Boot image until a program is loaded
  initial begin
    $readmemh("dv/nopProgram.hex", imem);
  end

  always_ff @(posedge clk) begin
    if (loadEn) begin
      imem[loadAddr] <= loadData;
    end
  end

  assign fetchIdx = pc[imemAw+1:2];
  assign instr    = imem[fetchIdx];

  // Word addressed so the byte offset is ignored
  assign dataIdx = dataAddr[dmemAw+1:2];
  assign dataOut = dmem[dataIdx];

  always_ff @(posedge clk) begin
    if (dataWrite) begin
      dmem[dataIdx] <= dataIn;
    end
  end

  // Stores from EX/MEM must land inside data memory
  assert property (@(posedge clk) dataWrite |-> (dataAddr[31:2] < dmemWords))
    else $error("Store to word %0d beyond data memory", dataAddr[31:2]);

endmodule

`default_nettype wire

// File: hw/Cpu.sv
`timescale 1ns/1ps
`default_nettype none

module Cpu import cpuPkg::*; #(
  parameter int imemWords = 64,
  parameter int dmemWords = 64
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         loadEn,
  input  logic [$clog2(imemWords)-1:0] loadAddr,
  input  logic [31:0]                  loadData,
  output retireT                       retire
);

  logic [31:0] pc;
  logic [31:0] instr;
  logic        stall;
  logic        branchTaken;
  logic [31:0] branchTarget;

  ifIdT  ifId;
  idExT  idEx;
  idExT  idExNext;
  exMemT exMem;
  memWbT memWb;

  ctrlT        decCtrl;
  logic [31:0] decImm;
  logic [4:0]  idRs1;
  logic [4:0]  idRs2;
  logic [31:0] idRs1Value;
  logic [31:0] idRs2Value;

  fwdSelE      fwdA;
  fwdSelE      fwdB;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        zero;

  logic [31:0] memData;
  logic [31:0] wbData;

  function automatic logic [31:0] fwdMux(input fwdSelE sel, input logic [31:0] regValue,
                                         input logic [31:0] memValue,
                                         input logic [31:0] wbValue);
    case (sel)
      fwdMem:  return memValue;
      fwdWb:   return wbValue;
      default: return regValue;
    endcase
  endfunction

  MemoryHandler #(
    .imemWords(imemWords),
    .dmemWords(dmemWords)
  ) memoryHandler (
    .clk      (clk),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .pc       (pc),
    .dataAddr (exMem.aluResult),
    .dataIn   (exMem.storeData),
    .dataWrite(exMem.memWrite),
    .instr    (instr),
    .dataOut  (memData)
  );

  // Fetch
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ifId <= '0;
    end else if (branchTaken) begin
      ifId <= '0;
    end else if (!stall) begin
      ifId <= '{valid: 1'b1, pc: pc, instr: instr};
    end
  end

  // Decode
  assign idRs1 = ifId.instr[19:15];
  assign idRs2 = ifId.instr[24:20];

  DecodeUnit decodeUnit (
    .clk  (clk),
    .instr(ifId.instr),
    .ctrl (decCtrl),
    .imm  (decImm)
  );

  RegisterFile registerFile (
    .clk     (clk),
    .arstN   (arstN),
    .rs1     (idRs1),
    .rs2     (idRs2),
    .rd      (memWb.rd),
    .wrData  (wbData),
    .wrEn    (memWb.regWrite),
    .rs1Value(idRs1Value),
    .rs2Value(idRs2Value)
  );

  HazardUnit hazardUnit (
    .clk        (clk),
    .arstN      (arstN),
    .idRs1      (idRs1),
    .idRs2      (idRs2),
    .exRs1      (idEx.rs1),
    .exRs2      (idEx.rs2),
    .exRd       (idEx.rd),
    .exMemRead  (idEx.ctrl.memRead),
    .memRd      (exMem.rd),
    .memRegWrite(exMem.regWrite),
    .wbRd       (memWb.rd),
    .wbRegWrite (memWb.regWrite),
    .stall      (stall),
    .fwdA       (fwdA),
    .fwdB       (fwdB)
  );

  always_comb begin
    idExNext          = '0;
    idExNext.valid    = ifId.valid;
    idExNext.pc       = ifId.pc;
    idExNext.rs1Value = idRs1Value;
    idExNext.rs2Value = idRs2Value;
    idExNext.rs1      = idRs1;
    idExNext.rs2      = idRs2;
    idExNext.rd       = ifId.instr[11:7];
    idExNext.imm      = decImm;
    idExNext.ctrl     = ifId.valid ? decCtrl : '0;
  end

  // Bubble on load-use, squash on taken branch
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else if (branchTaken || stall) begin
      idEx <= '0;
    end else begin
      idEx <= idExNext;
    end
  end

  // Execute
  assign opA  = fwdMux(fwdA, idEx.rs1Value, exMem.aluResult, wbData);
  assign opB  = fwdMux(fwdB, idEx.rs2Value, exMem.aluResult, wbData);
  assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

  Alu alu (
    .op    (idEx.ctrl.aluOp),
    .a     (opA),
    .b     (aluB),
    .result(aluResult),
    .zero  (zero)
  );

  assign branchTarget = idEx.pc + idEx.imm;
  assign branchTaken  = idEx.valid && idEx.ctrl.branch && zero;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem <= '{aluResult: aluResult, storeData: opB, rd: idEx.rd,
                 memRead: idEx.ctrl.memRead, memWrite: idEx.ctrl.memWrite,
                 memToReg: idEx.ctrl.memToReg, regWrite: idEx.ctrl.regWrite};
    end
  end

  // Memory
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWb <= '0;
    end else begin
      memWb <= '{memData: memData, aluResult: exMem.aluResult, rd: exMem.rd,
                 memToReg: exMem.memToReg, regWrite: exMem.regWrite};
    end
  end

  // Write-back and trace
  assign wbData = memWb.memToReg ? memWb.memData : memWb.aluResult;

  assign retire = '{valid: memWb.regWrite && (memWb.rd != 5'd0),
                    rd: memWb.rd, data: wbData};

endmodule

`default_nettype wire

// File: dv/CpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module CpuTb import cpuPkg::*;;

  localparam int imemWords = 64;
  localparam int dmemWords = 64;
  localparam int addrBits  = $clog2(imemWords);
  localparam int numTests  = 5;
  localparam int clkPeriod = 4;

  logic                clk;
  logic                arstN;
  logic                loadEn;
  logic [addrBits-1:0] loadAddr;
  logic [31:0]         loadData;
  retireT              retire;

  int seed;
  int errors;
  int checks;
  int edges;
  int firstRetire;
  int skipLeft;
  bit collecting;

  logic [31:0] prog [$];
  retireT      trace [$];
  retireT      expected [$];
  logic [31:0] refRegs [32];
  logic [31:0] refMem [int];

  Cpu #(
    .imemWords(imemWords),
    .dmemWords(dmemWords)
  ) dut (
    .clk     (clk),
    .arstN   (arstN),
    .loadEn  (loadEn),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .retire  (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (collecting) begin
      edges++;
    end
  end

  // Retire entries sampled mid-cycle
  always @(negedge clk) begin
    if (collecting && retire.valid) begin
      if (firstRetire < 0) begin
        firstRetire = edges;
      end
      trace.push_back(retire);
    end
  end

  task automatic checkRetire(input int idx, input retireT got, input retireT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: retire %0d is v%0b x%0d %h, expected v%0b x%0d %h",
               $time, idx, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
    end
  endtask

  task automatic checkCount(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Reference ISA model skips instructions jumped over by a taken BEQ
  function automatic bit executes();
    if (skipLeft > 0) begin
      skipLeft--;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      refRegs[rd] = value;
      expected.push_back(retireT'{valid: 1'b1, rd: rd, data: value});
    end
  endtask

  task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    prog.push_back({imm[11:0], rs1, 3'b000, rd, opImm});
    if (executes()) begin
      writeReg(rd, refRegs[rs1] + 32'(imm));
    end
  endtask

  task automatic aluRR(input aluOpE op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    f7 = (op == aluSub) ? 7'b0100000 : 7'b0000000;
    case (op)
      aluAnd:  f3 = 3'b111;
      aluOr:   f3 = 3'b110;
      aluSlt:  f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    prog.push_back({f7, rs2, rs1, f3, rd, opR});
    if (executes()) begin
      a = refRegs[rs1];
      b = refRegs[rs2];
      case (op)
        aluSub:  res = a - b;
        aluAnd:  res = a & b;
        aluOr:   res = a | b;
        aluSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: res = a + b;
      endcase
      writeReg(rd, res);
    end
  endtask

  task automatic storeWord(input logic [4:0] rs2, input logic [4:0] rs1, input int imm);
    prog.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore});
    if (executes()) begin
      refMem[int'((refRegs[rs1] + 32'(imm)) >> 2)] = refRegs[rs2];
    end
  endtask

  task automatic loadWord(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    prog.push_back({imm[11:0], rs1, 3'b010, rd, opLoad});
    if (executes()) begin
      writeReg(rd, refMem[int'((refRegs[rs1] + 32'(imm)) >> 2)]);
    end
  endtask

  function automatic logic [31:0] beqWord(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input int offWords);
    int off;
    off = offWords * 4;
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], opBranch};
  endfunction

  // Forward branches only
  task automatic branchEq(input logic [4:0] rs1, input logic [4:0] rs2, input int offWords);
    prog.push_back(beqWord(rs1, rs2, offWords));
    if (executes() && refRegs[rs1] == refRegs[rs2]) begin
      skipLeft = offWords - 1;
    end
  endtask

  task automatic startProgram();
    prog.delete();
    expected.delete();
    refMem.delete();
    skipLeft = 0;
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
    end
  endtask

  task automatic runAndCheck(input string name);
    int resetCycles;
    int waited;
    prog.push_back(beqWord(5'd0, 5'd0, 0));
    resetCycles = (prog.size() > 8) ? prog.size() : 8;
    @(posedge clk);
    #1;
    collecting = 1'b0;
    arstN      = 1'b0;
    for (int i = 0; i < resetCycles; i++) begin
      loadEn   = (i < prog.size());
      loadAddr = addrBits'(i);
      loadData = (i < prog.size()) ? prog[i] : 32'd0;
      @(posedge clk);
      #1;
    end
    loadEn = 1'b0;
    trace.delete();
    edges       = 0;
    firstRetire = -1;
    collecting  = 1'b1;
    arstN       = 1'b1;
    waited      = 0;
    while (trace.size() < expected.size() && waited < 150) begin
      @(posedge clk);
      waited++;
    end
    if (trace.size() < expected.size()) begin
      errors++;
      $display("Retire trace of %s stopped after %0d of %0d entries",
               name, trace.size(), expected.size());
    end
    // Drain so extra retires are caught
    repeat (8) @(posedge clk);
    checkCount({name, " retire count"}, trace.size(), expected.size());
    for (int i = 0; i < trace.size() && i < expected.size(); i++) begin
      checkRetire(i, trace[i], expected[i]);
    end
  endtask

  task automatic testAluOps();
    int r1;
    int r2;
    int r3;
    r1 = $random(seed) % 2048;
    r2 = $random(seed) % 2048;
    r3 = $random(seed) % 2048;
    startProgram();
    addi(5'd1, 5'd0, r1);
    addi(5'd2, 5'd0, r2);
    addi(5'd3, 5'd1, r3);
    aluRR(aluAdd, 5'd4, 5'd1, 5'd2);
    aluRR(aluSub, 5'd5, 5'd3, 5'd2);
    aluRR(aluAnd, 5'd6, 5'd1, 5'd3);
    aluRR(aluOr, 5'd7, 5'd2, 5'd3);
    aluRR(aluSlt, 5'd8, 5'd1, 5'd2);
    aluRR(aluSlt, 5'd9, 5'd2, 5'd1);
    runAndCheck("ALU ops");
    // Reset release edge plus four stages
    checkCount("first retire edge", firstRetire, 4);
  endtask

  task automatic testForwarding();
    startProgram();
    addi(5'd1, 5'd0, 300);
    aluRR(aluAdd, 5'd2, 5'd1, 5'd1);
    addi(5'd3, 5'd0, -45);
    aluRR(aluSub, 5'd4, 5'd1, 5'd3);
    aluRR(aluOr, 5'd5, 5'd2, 5'd3);
    aluRR(aluAnd, 5'd6, 5'd4, 5'd5);
    aluRR(aluSlt, 5'd7, 5'd6, 5'd1);
    runAndCheck("forwarding");
  endtask

  task automatic testLoadStore();
    startProgram();
    addi(5'd1, 5'd0, 1234);
    addi(5'd2, 5'd0, 8);
    storeWord(5'd1, 5'd2, 0);
    loadWord(5'd3, 5'd2, 0);
    aluRR(aluAdd, 5'd4, 5'd3, 5'd1);
    addi(5'd5, 5'd0, -77);
    storeWord(5'd5, 5'd2, 4);
    loadWord(5'd6, 5'd2, 4);
    addi(5'd7, 5'd6, 19);
    runAndCheck("load store");
  endtask

  task automatic testBranches();
    startProgram();
    addi(5'd1, 5'd0, 21);
    addi(5'd2, 5'd0, 21);
    branchEq(5'd1, 5'd2, 3);
    addi(5'd3, 5'd0, 1);
    addi(5'd4, 5'd0, 2);
    addi(5'd5, 5'd1, 3);
    branchEq(5'd1, 5'd3, 2);
    addi(5'd6, 5'd0, 7);
    addi(5'd7, 5'd5, 9);
    runAndCheck("branches");
  endtask

  task automatic testZeroReg();
    int r;
    r = $random(seed) % 2048;
    startProgram();
    addi(5'd1, 5'd0, r);
    addi(5'd0, 5'd1, 17);
    aluRR(aluAdd, 5'd2, 5'd0, 5'd1);
    addi(5'd0, 5'd0, 5);
    aluRR(aluAdd, 5'd3, 5'd0, 5'd0);
    aluRR(aluOr, 5'd0, 5'd1, 5'd2);
    aluRR(aluSub, 5'd4, 5'd0, 5'd1);
    runAndCheck("x0");
  endtask

  initial begin
    #(numTests * 200 * clkPeriod);
    $display("Timeout: the tests did not finish in the expected time");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed        = 87;
    errors      = 0;
    checks      = 0;
    edges       = 0;
    firstRetire = -1;
    skipLeft    = 0;
    collecting  = 1'b0;
    arstN       = 1'b0;
    loadEn      = 1'b0;
    loadAddr    = '0;
    loadData    = '0;
    testAluOps();
    testForwarding();
    testLoadStore();
    testBranches();
    testZeroReg();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/nopProgram.hex
// One 32-bit instruction word per line, starting at word 0
// 00000013 encodes addi x0, x0, 0
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013

// File: filelist.f
hw/cpuPkg.sv
hw/Alu.sv
hw/RegisterFile.sv
hw/DecodeUnit.sv
hw/HazardUnit.sv
hw/MemoryHandler.sv
hw/Cpu.sv
dv/CpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module CpuTb -f filelist.f -o VCpuTb

status=0
./obj_dir/VCpuTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** FAILED ***' sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
